//--- design/link_proto_pkg.sv
`default_nettype none

package link_proto_pkg;

    ////////////////////
    // stream byte
    ////////////////////
    typedef logic [7:0] byte_t;

    ////////////////////
    // packet identifiers
    ////////////////////
    localparam byte_t PID_SYNC = 8'h01;
    localparam byte_t PID_CMD  = 8'h1E;
    localparam byte_t PID_ACK  = 8'h2D;
    localparam byte_t PID_NAK  = 8'hA5;
    localparam byte_t PID_STL  = 8'hE1;

    // top nibble of the first payload byte
    localparam logic [3:0] HEAD_DIDX   = 4'h9;
    localparam logic [3:0] HEAD_DDIDX  = 4'h1;
    localparam logic [3:0] HEAD_DPARAM = 4'h5;

    ////////////////////
    // length field
    ////////////////////
    localparam int LEN_BYTES = 2;                          // length bytes after cmd pid
    localparam int LEN_MAX   = 15;                         // low nibble of 2nd length byte
    typedef logic [$clog2(LEN_MAX+1)-1:0] len_t;

    ////////////////////
    // crc-5, x^5+x^2+1
    ////////////////////
    localparam int CRC_W = 5;
    typedef logic [CRC_W-1:0] crc_t;
    localparam crc_t CRC_INIT = 5'h1f;
    localparam crc_t CRC_POLY = 5'h05;                     // msb term implied

endpackage

`default_nettype wire

//--- design/rx_cmd_pkg.sv
`default_nettype none

package rx_cmd_pkg;

    typedef logic [3:0] nib_t;                             // one command field
    typedef logic [31:0] cmd_t;                            // packed cache command

    // reported packet type
    typedef enum logic [3:0] {
        INIT   = 4'd0,
        ACK    = 4'd1,
        NAK    = 4'd2,
        STL    = 4'd3,
        DIDX   = 4'd5,
        DPARAM = 4'd6,
        DDIDX  = 4'd7,
        ERROR  = 4'd15
    } btype_e;

    ////////////////////
    // cache_cmd layout, bits 11..0 read as zero
    ////////////////////
    localparam int DEV_MSB  = 31;                          // device index
    localparam int DATA_MSB = 27;                          // data index
    localparam int FREQ_MSB = 23;                          // sample frequency
    localparam int FUP_MSB  = 19;                          // upper filter
    localparam int FLOW_MSB = 15;                          // lower filter

endpackage

`default_nettype wire

//--- design/rx_frame_if.sv
`timescale 1ns/100ps
`default_nettype none

interface rx_frame_if;

    link_proto_pkg::byte_t rxd;                            // byte of this cycle
    logic                  crc_clr;                        // hunting for sync
    logic                  crc_en;                         // byte is covered by crc
    logic                  pid_stb;
    logic                  hdr_stb;                        // first payload byte
    logic                  arg_stb;                        // second payload byte
    logic                  err_stb;
    link_proto_pkg::byte_t crc_val;                        // from crc block

    modport ctrl (
        output rxd, crc_clr, crc_en,
        output pid_stb, hdr_stb, arg_stb, err_stb,
        input  crc_val
    );

    modport crc (
        input  rxd, crc_clr, crc_en,
        output crc_val
    );

    modport dec (
        input rxd, crc_clr,
        input pid_stb, hdr_stb, arg_stb, err_stb
    );

endinterface

`default_nettype wire

//--- design/rx_frame_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire link_proto_pkg::byte_t rxd,
    input  wire logic                  done_ack,
    output logic                       done,
    rx_frame_if.ctrl                   frm
);

    typedef enum logic [2:0] {
        IDLE,
        HUNT,
        PID,
        LEN,
        BODY,
        CRC,
        ERR,
        DONE
    } state_e;

    state_e state;
    state_e state_nxt;

    link_proto_pkg::len_t cnt;                             // byte index within phase
    link_proto_pkg::len_t pay_len;                         // payload bytes L
    logic                 len_last;                        // last length byte on rxd
    logic                 body_last;                       // last payload byte on rxd

    assign len_last  = (state == LEN) &&
                       (cnt == link_proto_pkg::len_t'(link_proto_pkg::LEN_BYTES - 1));
    assign body_last = (state == BODY) && (cnt == pay_len - 1'b1);

    ////////////////////
    // state register
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: state_nxt = HUNT;
            HUNT: begin
                if (rxd == link_proto_pkg::PID_SYNC) state_nxt = PID;
            end
            PID: begin
                case (rxd)
                    link_proto_pkg::PID_CMD: state_nxt = LEN;
                    link_proto_pkg::PID_ACK,
                    link_proto_pkg::PID_NAK,
                    link_proto_pkg::PID_STL: state_nxt = DONE;  // handshake ends here
                    default:                 state_nxt = ERR;
                endcase
            end
            LEN: begin
                if (len_last) state_nxt = BODY;
            end
            BODY: begin
                if (body_last) state_nxt = CRC;
            end
            CRC: begin
                if (rxd == frm.crc_val) begin
                    state_nxt = DONE;
                end else begin
                    state_nxt = ERR;
                end
            end
            ERR:  state_nxt = DONE;
            DONE: begin
                if (done_ack) state_nxt = HUNT;
            end
            default: state_nxt = IDLE;
        endcase
    end

    ////////////////////
    // counters
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (len_last || body_last) begin
            cnt <= '0;                                     // next phase starts at 0
        end else if (state == LEN || state == BODY) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pay_len <= '0;
        end else if (len_last) begin
            pay_len <= rxd[3:0];                           // low nibble carries L
        end
    end

    // strobes, valid with their byte
    assign frm.rxd     = rxd;
    assign frm.crc_clr = (state == HUNT);
    assign frm.crc_en  = len_last || (state == BODY);
    assign frm.pid_stb = (state == PID);
    assign frm.hdr_stb = (state == BODY) && (cnt == 4'd0);
    assign frm.arg_stb = (state == BODY) && (cnt == 4'd1);
    assign frm.err_stb = (state == ERR);

    assign done = (state == DONE);                         // held until done_ack

endmodule

`default_nettype wire

//--- design/rx_crc5.sv
`timescale 1ns/100ps
`default_nettype none

module rx_crc5 (
    input wire logic clk,
    input wire logic rst,
    rx_frame_if.crc  frm
);

    link_proto_pkg::crc_t crc_q;

    // fold one byte in, msb first
    function automatic link_proto_pkg::crc_t crc_byte(
        input link_proto_pkg::crc_t  crc_in,
        input link_proto_pkg::byte_t din
    );
        link_proto_pkg::crc_t c;
        logic                 fb;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[link_proto_pkg::CRC_W-1] ^ din[i];
            c  = {c[link_proto_pkg::CRC_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ link_proto_pkg::CRC_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= link_proto_pkg::CRC_INIT;
        end else if (frm.crc_clr) begin
            crc_q <= link_proto_pkg::CRC_INIT;             // reseed while hunting
        end else if (frm.crc_en) begin
            crc_q <= crc_byte(crc_q, frm.rxd);
        end
    end

    assign frm.crc_val = link_proto_pkg::byte_t'(crc_q);   // top bits zero

endmodule

`default_nettype wire

//--- design/rx_cmd_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rx_cmd_decode (
    input  wire logic        clk,
    input  wire logic        rst,
    rx_frame_if.dec          frm,
    output rx_cmd_pkg::btype_e btype,
    output rx_cmd_pkg::cmd_t   cache_cmd
);

    rx_cmd_pkg::nib_t hdr;                                 // header nibble of rxd
    rx_cmd_pkg::nib_t dev_idx;
    rx_cmd_pkg::nib_t data_idx;
    rx_cmd_pkg::nib_t freq_samp;
    rx_cmd_pkg::nib_t filt_up;
    rx_cmd_pkg::nib_t filt_low;

    assign hdr = frm.rxd[7:4];

    ////////////////////
    // packet type
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype <= rx_cmd_pkg::INIT;
        end else if (frm.crc_clr) begin
            btype <= rx_cmd_pkg::INIT;
        end else if (frm.err_stb) begin
            btype <= rx_cmd_pkg::ERROR;
        end else if (frm.pid_stb) begin
            case (frm.rxd)
                link_proto_pkg::PID_ACK: btype <= rx_cmd_pkg::ACK;
                link_proto_pkg::PID_NAK: btype <= rx_cmd_pkg::NAK;
                link_proto_pkg::PID_STL: btype <= rx_cmd_pkg::STL;
                default:                 btype <= btype;   // cmd or bad pid
            endcase
        end else if (frm.hdr_stb) begin
            case (hdr)
                link_proto_pkg::HEAD_DIDX:   btype <= rx_cmd_pkg::DIDX;
                link_proto_pkg::HEAD_DDIDX:  btype <= rx_cmd_pkg::DDIDX;
                link_proto_pkg::HEAD_DPARAM: btype <= rx_cmd_pkg::DPARAM;
                default:                     btype <= btype;
            endcase
        end
    end

    ////////////////////
    // command fields
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_idx   <= '0;
            data_idx  <= '0;
            freq_samp <= '0;
        end else if (frm.hdr_stb) begin
            if (hdr == link_proto_pkg::HEAD_DIDX)   dev_idx   <= frm.rxd[3:0];
            if (hdr == link_proto_pkg::HEAD_DDIDX)  data_idx  <= frm.rxd[3:0];
            if (hdr == link_proto_pkg::HEAD_DPARAM) freq_samp <= frm.rxd[3:0];
        end
    end

    // filter nibbles follow a parameter header
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            filt_up  <= '0;
            filt_low <= '0;
        end else if (frm.arg_stb && btype == rx_cmd_pkg::DPARAM) begin
            filt_up  <= frm.rxd[7:4];
            filt_low <= frm.rxd[3:0];
        end
    end

    assign cache_cmd[rx_cmd_pkg::DEV_MSB  -: $bits(rx_cmd_pkg::nib_t)] = dev_idx;
    assign cache_cmd[rx_cmd_pkg::DATA_MSB -: $bits(rx_cmd_pkg::nib_t)] = data_idx;
    assign cache_cmd[rx_cmd_pkg::FREQ_MSB -: $bits(rx_cmd_pkg::nib_t)] = freq_samp;
    assign cache_cmd[rx_cmd_pkg::FUP_MSB  -: $bits(rx_cmd_pkg::nib_t)] = filt_up;
    assign cache_cmd[rx_cmd_pkg::FLOW_MSB -: $bits(rx_cmd_pkg::nib_t)] = filt_low;
    assign cache_cmd[rx_cmd_pkg::FLOW_MSB-$bits(rx_cmd_pkg::nib_t):0]  = '0;

endmodule

`default_nettype wire

//--- design/cmd_link_rx.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_link_rx (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire link_proto_pkg::byte_t rxd,
    input  wire logic                  done_ack,
    output logic                       done,
    output rx_cmd_pkg::btype_e         btype,
    output rx_cmd_pkg::cmd_t           cache_cmd
);

    ////////////////////
    // frame bus
    ////////////////////
    rx_frame_if frm ();

    ////////////////////
    // control
    ////////////////////
    rx_frame_ctrl rx_frame_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .done_ack (done_ack),
        .done     (done),
        .frm      (frm.ctrl)
    );

    ////////////////////
    // datapath
    ////////////////////
    rx_crc5 rx_crc5_inst (
        .clk (clk),
        .rst (rst),
        .frm (frm.crc)
    );

    rx_cmd_decode rx_cmd_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .frm       (frm.dec),
        .btype     (btype),
        .cache_cmd (cache_cmd)
    );

endmodule

`default_nettype wire

//--- dv/cmd_link_rx_tb_pkt.svh
`ifndef CMD_LINK_RX_TB_PKT_SVH
`define CMD_LINK_RX_TB_PKT_SVH

localparam int          NUM_PKT   = 14;
localparam int          MEM_DEPTH = NUM_PKT * 32;          // 27 bytes at most per packet
localparam logic [31:0] LFSR_SEED = 32'h3eda;

link_proto_pkg::byte_t pkt_mem [MEM_DEPTH];                // all packets back to back
int                    pkt_first [NUM_PKT];
int                    pkt_count [NUM_PKT];
rx_cmd_pkg::btype_e    exp_btype [NUM_PKT];
rx_cmd_pkg::cmd_t      exp_cmd [NUM_PKT];
int                    exp_lat [NUM_PKT];                  // cycles from last byte to done
int                    fill_ptr;
int                    pkt_ptr;
logic [31:0]           lfsr_q;

// reference copy of the command fields
rx_cmd_pkg::nib_t m_dev;
rx_cmd_pkg::nib_t m_data;
rx_cmd_pkg::nib_t m_freq;
rx_cmd_pkg::nib_t m_fup;
rx_cmd_pkg::nib_t m_flow;

////////////////////
// random source
////////////////////
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};         // taps 32, 22, 2, 1
endfunction

function automatic link_proto_pkg::byte_t take_bits(input int n);
    link_proto_pkg::byte_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v = {v[6:0], lfsr_q[31]};
    end
    return v;
endfunction

function automatic link_proto_pkg::byte_t idle_byte();
    link_proto_pkg::byte_t v;
    v = take_bits(8);
    if (v == link_proto_pkg::PID_SYNC) v = 8'h00;          // never a false sync
    return v;
endfunction

////////////////////
// crc-5 reference, x^5+x^2+1
////////////////////
function automatic link_proto_pkg::crc_t crc5_ref(input int first, input int count);
    link_proto_pkg::crc_t r;
    logic                 fb;
    r = link_proto_pkg::CRC_INIT;
    for (int i = first; i < first + count; i++) begin
        for (int b = 7; b >= 0; b--) begin
            fb = r[4] ^ pkt_mem[i][b];
            r  = {r[3], r[2], r[1] ^ fb, r[0], fb};        // x^2 and x^0 taps
        end
    end
    return r;
endfunction

function automatic rx_cmd_pkg::cmd_t pack_cmd();
    rx_cmd_pkg::cmd_t c;
    c = '0;
    c[rx_cmd_pkg::DEV_MSB  -: 4] = m_dev;
    c[rx_cmd_pkg::DATA_MSB -: 4] = m_data;
    c[rx_cmd_pkg::FREQ_MSB -: 4] = m_freq;
    c[rx_cmd_pkg::FUP_MSB  -: 4] = m_fup;
    c[rx_cmd_pkg::FLOW_MSB -: 4] = m_flow;
    return c;
endfunction

////////////////////
// packet builders
////////////////////
task automatic push_byte(input link_proto_pkg::byte_t b);
    pkt_mem[fill_ptr] = b;
    fill_ptr++;
endtask

// random idle bytes, then sync
task automatic open_packet();
    int n;
    pkt_first[pkt_ptr] = fill_ptr;
    n = int'(take_bits(3));
    repeat (n) push_byte(idle_byte());
    push_byte(link_proto_pkg::PID_SYNC);
endtask

task automatic close_packet(input rx_cmd_pkg::btype_e bt, input int lat);
    pkt_count[pkt_ptr] = fill_ptr - pkt_first[pkt_ptr];
    exp_btype[pkt_ptr] = bt;
    exp_lat[pkt_ptr]   = lat;
    exp_cmd[pkt_ptr]   = pack_cmd();
    pkt_ptr++;
endtask

task automatic add_handshake(input link_proto_pkg::byte_t pid, input rx_cmd_pkg::btype_e bt);
    open_packet();
    push_byte(pid);
    close_packet(bt, 1);
endtask

task automatic add_bad_pid(input link_proto_pkg::byte_t pid);
    open_packet();
    push_byte(pid);
    close_packet(rx_cmd_pkg::ERROR, 2);                    // one error cycle first
endtask

task automatic add_command(input logic [3:0] head, input logic [3:0] val, input int len,
                           input link_proto_pkg::byte_t arg, input logic corrupt);
    int                    first;
    link_proto_pkg::byte_t rnd;
    link_proto_pkg::byte_t crc_b;
    rx_cmd_pkg::btype_e    bt;
    open_packet();
    push_byte(link_proto_pkg::PID_CMD);
    push_byte(take_bits(8));                               // first length byte
    first = fill_ptr;
    rnd   = take_bits(4);
    push_byte({rnd[3:0], 4'(len)});
    push_byte({head, val});
    if (len >= 2) push_byte(arg);
    for (int k = 2; k < len; k++) push_byte(take_bits(8));
    bt = rx_cmd_pkg::INIT;
    if (head == link_proto_pkg::HEAD_DIDX) begin
        m_dev = val;
        bt    = rx_cmd_pkg::DIDX;
    end else if (head == link_proto_pkg::HEAD_DDIDX) begin
        m_data = val;
        bt     = rx_cmd_pkg::DDIDX;
    end else if (head == link_proto_pkg::HEAD_DPARAM) begin
        m_freq = val;
        bt     = rx_cmd_pkg::DPARAM;
        if (len >= 2) {m_fup, m_flow} = arg;
    end
    crc_b = {3'b000, crc5_ref(first, fill_ptr - first)};
    if (corrupt) crc_b = crc_b ^ 8'h04;
    push_byte(crc_b);
    close_packet(corrupt ? rx_cmd_pkg::ERROR : bt, corrupt ? 2 : 1);
endtask

task automatic add_random_command(input logic [3:0] head);
    link_proto_pkg::byte_t v;
    link_proto_pkg::byte_t l;
    link_proto_pkg::byte_t a;
    int                    len;
    v   = take_bits(4);
    l   = take_bits(4);
    a   = take_bits(8);
    len = (l == 8'h00) ? 15 : int'(l);
    if (head == link_proto_pkg::HEAD_DPARAM && len < 2) len = 2;
    add_command(head, v[3:0], len, a, 1'b0);
endtask

// one row per packet: header/pid, field value, length, second payload byte, bad crc
task automatic build_table();
    fill_ptr = 0;
    pkt_ptr  = 0;
    m_dev    = '0;
    m_data   = '0;
    m_freq   = '0;
    m_fup    = '0;
    m_flow   = '0;
    add_handshake(link_proto_pkg::PID_ACK, rx_cmd_pkg::ACK);
    add_handshake(link_proto_pkg::PID_NAK, rx_cmd_pkg::NAK);
    add_handshake(link_proto_pkg::PID_STL, rx_cmd_pkg::STL);
    add_command(link_proto_pkg::HEAD_DIDX,   4'h6, 1,  8'h00, 1'b0);
    add_command(link_proto_pkg::HEAD_DDIDX,  4'hb, 3,  8'h77, 1'b0);
    add_command(link_proto_pkg::HEAD_DPARAM, 4'h3, 2,  8'hc7, 1'b0);
    add_handshake(link_proto_pkg::PID_ACK, rx_cmd_pkg::ACK);
    add_bad_pid(8'h3c);
    add_command(link_proto_pkg::HEAD_DIDX,   4'ha, 4,  8'h12, 1'b1);
    add_command(link_proto_pkg::HEAD_DPARAM, 4'he, 15, 8'h5a, 1'b0);
    add_random_command(link_proto_pkg::HEAD_DDIDX);
    add_random_command(link_proto_pkg::HEAD_DPARAM);
    add_random_command(link_proto_pkg::HEAD_DIDX);
    add_handshake(link_proto_pkg::PID_STL, rx_cmd_pkg::STL);
endtask

`endif

//--- dv/cmd_link_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_link_rx_tb;

    localparam int                    CLK_PERIOD  = 8;
    localparam int                    RST_CYCLES  = 3;
    localparam int                    CYC_PER_PKT = 40;
    localparam int                    DONE_WAIT   = 8;     // longest wait for done
    localparam link_proto_pkg::byte_t IDLE_BYTE   = 8'h00;

    logic                  clk;
    logic                  rst;
    link_proto_pkg::byte_t rxd;
    logic                  done_ack;
    logic                  done;
    rx_cmd_pkg::btype_e    btype;
    rx_cmd_pkg::cmd_t      cache_cmd;

    int err_cnt;
    int chk_cnt;

    `include "cmd_link_rx_tb_pkt.svh"

    localparam int WDOG_CYCLES = NUM_PKT * CYC_PER_PKT + RST_CYCLES + 4;

    cmd_link_rx cmd_link_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .done_ack  (done_ack),
        .done      (done),
        .btype     (btype),
        .cache_cmd (cache_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////
    // watchdog
    ////////////////////
    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////
    // driver and checker
    ////////////////////
    initial begin
        int wait_cyc;
        int hold;
        int pkt_err;
        rst      = 1'b1;
        rxd      = IDLE_BYTE;
        done_ack = 1'b0;
        err_cnt  = 0;
        chk_cnt  = 0;
        lfsr_q   = LFSR_SEED;
        build_table();

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        compare_val("done", done, 1'b0);
        compare_val("btype", btype, rx_cmd_pkg::INIT);
        compare_val("cache_cmd", cache_cmd, 32'h0);
        rst = 1'b0;
        repeat (2) @(negedge clk);                         // idle cycle, then hunting

        for (int i = 0; i < NUM_PKT; i++) begin
            pkt_err = err_cnt;
            for (int k = 0; k < pkt_count[i]; k++) begin
                compare_val("done", done, 1'b0);
                rxd = pkt_mem[pkt_first[i] + k];
                @(negedge clk);
            end
            rxd      = IDLE_BYTE;
            wait_cyc = 1;
            while (!done && wait_cyc < DONE_WAIT) begin
                @(negedge clk);
                wait_cyc++;
            end

            if (!done) begin
                err_cnt++;
                $display("packet %0d: done did not rise within %0d cycles", i, DONE_WAIT);
            end else begin
                compare_val("done_latency", wait_cyc, exp_lat[i]);
                compare_val("btype", btype, exp_btype[i]);
                compare_val("cache_cmd", cache_cmd, exp_cmd[i]);
                hold = int'(take_bits(2));
                repeat (hold) begin
                    rxd = take_bits(8);                    // ignored while done is high
                    @(negedge clk);
                    compare_val("done", done, 1'b1);
                end
                rxd      = IDLE_BYTE;
                done_ack = 1'b1;
                @(negedge clk);
                done_ack = 1'b0;
                compare_val("done", done, 1'b0);
                @(negedge clk);
                compare_val("btype", btype, rx_cmd_pkg::INIT);
            end

            $display("packet %2d: %2d bytes, btype %0d, cache_cmd 0x%08h, %s",
                     i, pkt_count[i], exp_btype[i], exp_cmd[i],
                     (err_cnt == pkt_err) ? "ok" : "errors");
        end

        $display("%0d packets, %0d checks, %0d errors", NUM_PKT, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cmd_link_rx.f
+incdir+dv
design/link_proto_pkg.sv
design/rx_cmd_pkg.sv
design/rx_frame_if.sv
design/rx_frame_ctrl.sv
design/rx_crc5.sv
design/rx_cmd_decode.sv
design/cmd_link_rx.sv
dv/cmd_link_rx_tb.sv

//--- Makefile
TOP := cmd_link_rx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f cmd_link_rx.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
